// File: src/sifh_settings.svh
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// timestamp width from the TDC
`define Np 12

// bin index width, coarse bin is the upper field and fine bin the lower
`define Nb 6

// bins per histogram, equal to 2**Nb
`define BIN_NUM 64

// bin count width, counts saturate at all ones
`define peakMax 8

// hits accepted per pass
`define HITS_PER_HIS 32

`endif

// File: src/sifhPkg.sv
package sifhPkg;

    // measurement sequencer states
    typedef enum logic [2:0] {
        clear     = 3'd0, // zero the whole SRAM
        build     = 3'd1, // histogram incoming hits
        findPeak  = 3'd2, // sweep for the maximum bin
        setWindow = 3'd3, // latch coarse peak as filter
        report    = 3'd4  // result strobe
    } stateT;

    // which of the two histogram passes is running
    typedef enum logic {
        coarse = 1'b0, // bins from upper timestamp bits
        fine   = 1'b1  // bins from lower bits, windowed
    } passT;

endpackage

// File: src/ramPortIf.sv
`timescale 1ns/10ps
`include "sifh_settings.svh"

interface ramPortIf;

    logic [`Nb-1:0]      waddr;     // write address
    logic                wEnable;   // write strobe
    logic [`peakMax-1:0] newCounts; // write data
    logic [`Nb-1:0]      raddr;     // read address
    logic                rEnable;   // read strobe
    logic [`peakMax-1:0] counts;    // read data, one cycle after raddr

    // SRAM user side
    modport client (
        output waddr, wEnable, newCounts, raddr, rEnable,
        input  counts
    );

    // arbiter / SRAM side
    modport host (
        input  waddr, wEnable, newCounts, raddr, rEnable,
        output counts
    );

endinterface

// File: src/histogramBuilder.sv
`timescale 1ns/10ps
`include "sifh_settings.svh"

module histogramBuilder (
    input  logic                clk,
    input  logic                res,
    input  logic                start,
    input  sifhPkg::passT       pass,
    input  logic [`Nb-1:0]      window,
    input  logic [`Np-1:0]      data,
    input  logic                hit,
    output logic                wrEn,
    output logic                done,
    ramPortIf.client            mem
);

    localparam int HW = $clog2(`HITS_PER_HIS);
    localparam int unsigned LAST_HIT = `HITS_PER_HIS - 1;

    logic                active;    // accepting hits
    logic                busy;      // between start and done
    logic [HW-1:0]       hitCnt;    // accepted hits this pass
    logic                accept;
    logic                keep;      // hit passes the window filter
    logic [`Nb-1:0]      coarseBin;
    logic [`Nb-1:0]      bin;

    logic                s1Valid;   // read data arriving
    logic [`Nb-1:0]      s1Bin;
    logic                s2Valid;   // write in progress
    logic [`Nb-1:0]      s2Bin;
    logic [`peakMax-1:0] s2Count;
    logic                wbValid;   // write of the previous cycle
    logic [`Nb-1:0]      wbBin;
    logic [`peakMax-1:0] wbCount;

    logic [`peakMax-1:0] srcCount;  // newest known count of s1Bin
    logic [`peakMax-1:0] incCount;

    assign wrEn      = active;
    assign accept    = hit && active;
    assign coarseBin = data[`Np-1 -: `Nb];
    assign keep      = (pass == sifhPkg::coarse) || (coarseBin == window);
    assign bin       = (pass == sifhPkg::coarse) ? coarseBin : data[`Nb-1:0];

    // stage 1 read is issued in the accept cycle
    assign mem.raddr   = bin;
    assign mem.rEnable = accept && keep;

    // SRAM returns stale data while a same-bin write is pending or just landed
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            srcCount = s2Count;    // hit right ahead
        end else if (wbValid && (wbBin == s1Bin)) begin
            srcCount = wbCount;    // written while we read
        end else begin
            srcCount = mem.counts;
        end
    end

    assign incCount = (srcCount == {`peakMax{1'b1}}) ? srcCount : srcCount + 1'b1;

    // stage 2 write
    assign mem.waddr     = s2Bin;
    assign mem.wEnable   = s2Valid;
    assign mem.newCounts = s2Count;

    assign done = busy && !active && !s1Valid && !s2Valid; // pipeline drained

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active  <= 1'b0;
            busy    <= 1'b0;
            hitCnt  <= '0;
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            if (start) begin
                active <= 1'b1;
                busy   <= 1'b1;
                hitCnt <= '0;
            end else if (accept) begin
                hitCnt <= hitCnt + 1'b1;
                if (hitCnt == LAST_HIT[HW-1:0]) begin
                    active <= 1'b0; // quota reached, filtered hits included
                end
            end
            if (done) begin
                busy <= 1'b0;
            end
            s1Valid <= accept && keep;
            s2Valid <= s1Valid;
            wbValid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= bin;
        s2Bin   <= s1Bin;
        s2Count <= incCount;
        wbBin   <= s2Bin;
        wbCount <= s2Count;
    end

endmodule

// File: src/peakFinder.sv
`timescale 1ns/10ps
`include "sifh_settings.svh"

module peakFinder (
    input  logic                clk,
    input  logic                res,
    input  logic                start,
    output logic [`Nb-1:0]      peakBin,
    output logic [`peakMax-1:0] peakCount,
    output logic                done,
    ramPortIf.client            mem
);

    localparam int unsigned LAST_BIN = `BIN_NUM - 1;

    logic           reading;  // read sweep running
    logic [`Nb-1:0] rdAddr;
    logic           cmpValid; // mem.counts holds bin cmpBin
    logic [`Nb-1:0] cmpBin;

    assign mem.raddr   = rdAddr;
    assign mem.rEnable = reading;

    // read only client
    assign mem.waddr     = '0;
    assign mem.wEnable   = 1'b0;
    assign mem.newCounts = '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            reading  <= 1'b0;
            rdAddr   <= '0;
            cmpValid <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (start) begin
                reading <= 1'b1;
                rdAddr  <= '0;
            end else if (reading) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == LAST_BIN[`Nb-1:0]) begin
                    reading <= 1'b0;
                end
            end
            cmpValid <= reading;
            done     <= cmpValid && (cmpBin == LAST_BIN[`Nb-1:0]); // last compare done
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= rdAddr;
        // bin 0 seeds the maximum, strictly greater keeps ties at the lowest bin
        if (cmpValid && ((cmpBin == '0) || (mem.counts > peakCount))) begin
            peakBin   <= cmpBin;
            peakCount <= mem.counts;
        end
    end

endmodule

// File: src/sifhTop.sv
`timescale 1ns/10ps
`include "sifh_settings.svh"

module sifhTop (
    input  logic                clk,
    input  logic                res,
    input  logic [`Np-1:0]      data,
    input  logic                hit,
    input  logic [`peakMax-1:0] counts,
    output logic [`Nb-1:0]      waddr,
    output logic [`Nb-1:0]      raddr,
    output logic                wEnable,
    output logic                rEnable,
    output logic [`peakMax-1:0] newCounts,
    output logic                wrEn,
    output logic [2*`Nb-1:0]    peakBin,
    output logic [`peakMax-1:0] peakCount,
    output logic                peakValid
);

    localparam int unsigned LAST_BIN = `BIN_NUM - 1;

    sifhPkg::stateT      state;
    sifhPkg::stateT      nextState;
    sifhPkg::passT       pass;
    logic [`Nb-1:0]      clrCnt;    // clear write address
    logic                clrWe;     // clear write active
    logic [`Nb-1:0]      window;    // coarse peak bin
    logic                buildStart;
    logic                buildDone;
    logic                findStart;
    logic                findDone;
    logic                fineDone;
    logic [`Nb-1:0]      findBin;
    logic [`peakMax-1:0] findCount;

    ramPortIf bIf ();
    ramPortIf pIf ();

    histogramBuilder i_builder (
        .clk    (clk),
        .res    (res),
        .start  (buildStart),
        .pass   (pass),
        .window (window),
        .data   (data),
        .hit    (hit),
        .wrEn   (wrEn),
        .done   (buildDone),
        .mem    (bIf.client)
    );

    peakFinder i_finder (
        .clk       (clk),
        .res       (res),
        .start     (findStart),
        .peakBin   (findBin),
        .peakCount (findCount),
        .done      (findDone),
        .mem       (pIf.client)
    );

    // starts fire in the last cycle of the previous state
    assign buildStart = (state == sifhPkg::clear) && clrWe && (clrCnt == LAST_BIN[`Nb-1:0]);
    assign findStart  = (state == sifhPkg::build) && buildDone;
    assign fineDone   = (state == sifhPkg::findPeak) && findDone && (pass == sifhPkg::fine);

    always_comb begin
        nextState = state;
        case (state)
            sifhPkg::clear:     if (buildStart) nextState = sifhPkg::build;
            sifhPkg::build:     if (buildDone) nextState = sifhPkg::findPeak;
            sifhPkg::findPeak: begin
                if (findDone) begin
                    nextState = (pass == sifhPkg::coarse) ? sifhPkg::setWindow : sifhPkg::report;
                end
            end
            sifhPkg::setWindow: nextState = sifhPkg::clear; // fine pass reruns clear
            default:            nextState = sifhPkg::clear; // report
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sifhPkg::clear;
            pass      <= sifhPkg::coarse;
            clrWe     <= 1'b0;
            clrCnt    <= '0;
            peakValid <= 1'b0;
        end else begin
            state <= nextState;
            clrWe <= (nextState == sifhPkg::clear);
            if (clrWe) begin
                clrCnt <= clrCnt + 1'b1; // wraps to 0 for the next clear
            end
            if (state == sifhPkg::setWindow) begin
                pass <= sifhPkg::fine;
            end else if (state == sifhPkg::report) begin
                pass <= sifhPkg::coarse;
            end
            peakValid <= fineDone; // high during report only
        end
    end

    always_ff @(posedge clk) begin
        if (state == sifhPkg::setWindow) begin
            window <= findBin;
        end
        if (fineDone) begin
            peakBin   <= {window, findBin};
            peakCount <= findCount;
        end
    end

    // SRAM port owner follows the state
    always_comb begin
        waddr     = '0;
        raddr     = '0;
        wEnable   = 1'b0;
        rEnable   = 1'b0;
        newCounts = '0;
        case (state)
            sifhPkg::clear: begin
                waddr   = clrCnt;
                wEnable = clrWe;
            end
            sifhPkg::build: begin
                waddr     = bIf.waddr;
                wEnable   = bIf.wEnable;
                newCounts = bIf.newCounts;
                raddr     = bIf.raddr;
                rEnable   = bIf.rEnable;
            end
            sifhPkg::findPeak: begin
                waddr     = pIf.waddr;
                wEnable   = pIf.wEnable;
                newCounts = pIf.newCounts;
                raddr     = pIf.raddr;
                rEnable   = pIf.rEnable;
            end
            default: ;
        endcase
    end

    assign bIf.counts = counts;
    assign pIf.counts = counts;

endmodule

// File: test/sifh_checker.sv
`timescale 1ns/10ps
`include "sifh_settings.svh"

module sifhChecker (
    input logic           clk,
    input logic           res,
    input sifhPkg::stateT state,
    input logic [`Nb-1:0] waddr,
    input logic [`Nb-1:0] raddr,
    input logic           wEnable,
    input logic           rEnable,
    input logic           wrEn,
    input logic           peakValid
);

    int errCount = 0; // failed assertions, polled by the testbench

    writeAddrRange: assert property (@(posedge clk) disable iff (!res)
        wEnable |-> !$isunknown(waddr) && (waddr < `BIN_NUM))
        else begin
            $error("write address outside the histogram");
            errCount++;
        end

    readAddrRange: assert property (@(posedge clk) disable iff (!res)
        rEnable |-> !$isunknown(raddr) && (raddr < `BIN_NUM))
        else begin
            $error("read address outside the histogram");
            errCount++;
        end

    // result strobe is a single pulse
    validPulse: assert property (@(posedge clk) disable iff (!res)
        peakValid |=> !peakValid)
        else begin
            $error("peakValid held longer than one cycle");
            errCount++;
        end

    readyInBuild: assert property (@(posedge clk) disable iff (!res)
        wrEn |-> (state == sifhPkg::build))
        else begin
            $error("wrEn high outside build");
            errCount++;
        end

    // the sweep only reads
    noWriteInSweep: assert property (@(posedge clk) disable iff (!res)
        (state == sifhPkg::findPeak) |-> !wEnable)
        else begin
            $error("SRAM write during findPeak");
            errCount++;
        end

endmodule

bind sifhTop sifhChecker i_checker (.*);

// File: test/sifhTb.sv
`timescale 1ns/10ps
`include "sifh_settings.svh"

module sifhTb;

    localparam int NREC   = 3;            // records in the test file
    localparam int HITS   = `HITS_PER_HIS;
    localparam int RECLEN = 2 * HITS + 2; // timestamps, peakBin, peakCount
    localparam int LIMIT  = NREC * 600;   // cycle budget for the whole run

    logic                clk;
    logic                res;
    logic [`Np-1:0]      data;
    logic                hit;
    logic [`peakMax-1:0] counts = '0;     // SRAM read data register
    logic [`Nb-1:0]      waddr;
    logic [`Nb-1:0]      raddr;
    logic                wEnable;
    logic                rEnable;
    logic [`peakMax-1:0] newCounts;
    logic                wrEn;
    logic [2*`Nb-1:0]    peakBin;
    logic [`peakMax-1:0] peakCount;
    logic                peakValid;

    logic [`Np-1:0]      vec [0:NREC*RECLEN-1]; // test file contents
    logic [`peakMax-1:0] ram [0:`BIN_NUM-1];    // external histogram SRAM
    int                  shadow [0:`BIN_NUM-1]; // expected counts of the current pass
    int                  cycles = 0;

    sifhTop i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("Fail at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expVal, actVal);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // binning and window rule for one offered hit
    task automatic expectHit(input logic [`Np-1:0] ts, input int p, input logic [`Nb-1:0] window);
        logic [`Nb-1:0] b;
        if ((p == 0) || (ts[`Np-1 -: `Nb] == window)) begin
            b = (p == 0) ? ts[`Np-1 -: `Nb] : ts[`Nb-1:0];
            if (shadow[b] < (1 << `peakMax) - 1) begin
                shadow[b] = shadow[b] + 1; // saturating count
            end
        end
    endtask

    task automatic driveHit(input logic [`Np-1:0] ts, input int gap);
        hit = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #5;
        end
        checkValue("wrEn", 1'b1, wrEn); // quota not yet reached
        hit  = 1'b1;
        data = ts;
        @(posedge clk);
        #5;
    endtask

    task automatic waitReady();
        while (!wrEn) begin
            @(posedge clk);
            #5;
        end
    endtask

    // offered while wrEn is low, must leave no trace
    task automatic offerDropped(input logic [`Np-1:0] ts);
        hit  = 1'b1;
        data = ts;
        repeat (3) begin
            @(posedge clk);
            #5;
        end
        hit = 1'b0;
    endtask

    // simple dual-port SRAM, a same-address read returns the old value
    always @(posedge clk) begin
        if (rEnable) begin
            if (!wrEn) begin
                checkValue($sformatf("sram[%0d]", raddr), shadow[raddr], ram[raddr]); // sweep
            end
            counts <= ram[raddr];
        end
        if (wEnable) begin
            ram[waddr] <= newCounts;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped reporting results", cycles);
            $display("TB FAILED");
            $fatal(1);
        end else if (i_dut.i_checker.errCount != 0) begin
            $display("a protocol assertion in the checker failed");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        logic [`Np-1:0] ts;
        logic [`Np-1:0] prev;
        logic [`Nb-1:0] window;
        logic [31:0]    fill;
        int             base;
        int             gap;

        res  = 1'b0;
        hit  = 1'b0;
        data = '0;
        void'($urandom(94848));
        for (int a = 0; a < `BIN_NUM; a++) begin
            fill   = a * 37 + 11;          // leftovers that clear has to remove
            ram[a] = fill[`peakMax-1:0];
        end
        $readmemh("test/sifh_tests.txt", vec);
        if ($isunknown(vec[NREC*RECLEN-1])) begin
            $display("could not read all records from test/sifh_tests.txt");
            $display("TB FAILED");
            $fatal(1);
        end
        repeat (4) @(posedge clk);
        #5;
        res = 1'b1;
        checkValue("wrEn", 1'b0, wrEn);

        for (int r = 0; r < NREC; r++) begin
            base   = r * RECLEN;
            window = vec[base + 2 * HITS][`Np-1 -: `Nb]; // coarse part of expected peakBin
            for (int p = 0; p < 2; p++) begin
                waitReady();
                for (int b = 0; b < `BIN_NUM; b++) begin
                    shadow[b] = 0;
                end
                prev = ~vec[base + p * HITS];
                for (int h = 0; h < HITS; h++) begin
                    ts  = vec[base + p * HITS + h];
                    gap = (ts == prev) ? 0 : int'($urandom % 4); // repeats back to back
                    expectHit(ts, p, window);
                    driveHit(ts, gap);
                    prev = ts;
                end
                checkValue("wrEn", 1'b0, wrEn); // quota reached
                offerDropped(vec[base + 2 * HITS]);
            end
            while (!peakValid) begin
                @(posedge clk);
                #5;
            end
            checkValue("peakBin", vec[base + 2 * HITS], peakBin);
            checkValue("peakCount", vec[base + 2 * HITS + 1], peakCount);
        end

        if (i_dut.i_checker.errCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("a protocol assertion in the checker failed");
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

// File: sifh.f
+incdir+src
src/sifhPkg.sv
src/ramPortIf.sv
src/histogramBuilder.sv
src/peakFinder.sv
src/sifhTop.sv
test/sifh_checker.sv
test/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - include_dirs:
      - src
    files:
      - src/sifhPkg.sv
      - src/ramPortIf.sv
      - src/histogramBuilder.sv
      - src/peakFinder.sv
      - src/sifhTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/sifh_checker.sv
      - test/sifhTb.sv

// File: test/sifh_tests.txt
// per record: 32 coarse pass timestamps, then 32 fine pass timestamps (16 per line)
// then the expected peakBin {coarse, fine} and peakCount
283 283 541 29F 541 283 000 FFF 2A0 545 545 3C1 2BF 541 280 548
281 54A 2B0 54F 3C1 000 283 55A 3C1 541 FC0 3C2 000 7C0 7C0 3C3
283 283 283 2A5 2A5 543 283 2BF 2A5 FFF 000 283 2A5 541 280 2BF
2A5 2A5 283 7C5 2BF 2BF 2BF 283 2A5 2A5 583 2BF 3C3 281 281 2A5
2A5 09
7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5
7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5 7C5
7C5 7C5 7C5 7C5 283 283 283 283 283 283 283 283 283 283 283 283
283 283 283 283 283 283 283 283 7C5 7C5 7C5 7C5 283 283 283 283
7C5 08
C01 081 C01 081 C02 C02 081 C3F 080 C00 123 C01 081 C01 0BF C05
081 C10 081 C10 081 FFF FFF FFF 081 C20 081 123 123 E00 E00 E00
081 C40 BFF 081 081 C40 C7F BC0 123 FFF 000 C40 C40 BFF 081 7C5
C40 C40 C40 C40 BFF BFF 081 081 081 081 081 081 123 123 000 FFF
C00 00
